/* project.f */
ptwPkg.sv
pteStatusIf.sv
levelCounter.sv
walkAddrGen.sv
pteCheck.sv
pteStore.sv
walkFsm.sv
ptwTop.sv
ptwProps.sv
tbPtw.sv

/* Bender.yml */
package:
  name: ptw

sources:
  - files:
      - ptwPkg.sv
      - pteStatusIf.sv
      - levelCounter.sv
      - walkAddrGen.sv
      - pteCheck.sv
      - pteStore.sv
      - walkFsm.sv
      - ptwTop.sv
  - target: test
    files:
      - ptwProps.sv
      - tbPtw.sv

/* tbPtw.sv */
// directed testbench for the page table walker, memory model, tests and summary
`timescale 1ns/100ps

module tbPtw;

  localparam int clkPeriod  = 100;
  localparam int vaBits     = ptwPkg::OFFSET_BITS + 3 * ptwPkg::VPN_BITS;
  localparam int numWalks   = 12;
  localparam int wdCycles   = 4 + numWalks * 20 * 4;  // stall-free budget, times 4 for stalls
  localparam logic [vaBits-1:0] testVa = {9'h0a5, 9'h13c, 9'h0f7, 12'h123};
  localparam ptwPkg::ppnT pagePpn = 44'h3_4567;

  logic clk, arstN, tlbMiss, missIsData, adUpdateEn, memStall, memAccessFault, flush;
  ptwPkg::accessT    access;
  logic [vaBits-1:0] vAdr;
  ptwPkg::ppnT       satpPpn;
  ptwPkg::pteT       memRdData, memWrData, pte;
  ptwPkg::paT        memAdr;
  logic [1:0]        pageType;
  logic memRead, memWrite, itlbWrite, dtlbWrite, pageFault, accessFault, walkBusy;

  ptwPkg::pteT mem [ptwPkg::paT];  // sparse page table memory
  bit          faultSet [ptwPkg::paT];
  ptwPkg::paT  rdLog[$];
  ptwPkg::paT  wrAdrLog[$];
  ptwPkg::pteT wrDataLog[$];
  logic [31:0] lcgState = 32'h2515_9c7a;
  logic [31:0] rnd;
  bit          stallOn;
  int          checks, errors, testErrs, latency;
  logic        gotItlb, gotDtlb, gotPf, gotAf;
  ptwPkg::pteT gotPte;
  logic [1:0]  gotType;

  ptwTop u_ptwTop (.*);

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  always @(posedge clk) begin
    rnd = nextRand();
    memStall <= stallOn & rnd[19];  // about half the cycles stall
  end

  // read data follows the address half a cycle later, stable for the sampling edge
  always @(negedge clk) begin
    memRdData      <= mem.exists(memAdr) ? mem[memAdr] : '0;
    memAccessFault <= memRead & faultSet.exists(memAdr);
    if (memRead && !memStall) rdLog.push_back(memAdr);
    if (memWrite && !memStall) begin
      mem[memAdr] = memWrData;
      wrAdrLog.push_back(memAdr);
      wrDataLog.push_back(memWrData);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////
  function automatic ptwPkg::paT entryAdr(ptwPkg::ppnT ppn, logic [8:0] vpn);
    return {ppn, vpn, 3'b000};  // entry address rule
  endfunction

  function automatic logic [8:0] vpnOf(int lvl);
    return testVa[12 + lvl * 9 +: 9];
  endfunction

  function automatic ptwPkg::ppnT tblPpn(int lvl);
    return 44'h100 + ptwPkg::ppnT'(2 - lvl);  // root at 0x100, then one page per level
  endfunction

  function automatic ptwPkg::pteT mkPte(ptwPkg::ppnT ppn, logic [9:0] flags);
    return {10'b0, ppn, flags};
  endfunction

  task automatic compareVal(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // pointers from the root down to leafLvl, then the given entry
  task automatic buildWalk(input int leafLvl, input ptwPkg::pteT leafPte);
    mem.delete();
    faultSet.delete();
    for (int lvl = 2; lvl > leafLvl; lvl--) begin
      mem[entryAdr(tblPpn(lvl), vpnOf(lvl))] = mkPte(tblPpn(lvl - 1), 10'h001);
    end
    mem[entryAdr(tblPpn(leafLvl), vpnOf(leafLvl))] = leafPte;
  endtask

  // raise a miss, wait for a TLB write or fault, drop the miss on the next edge
  task automatic runWalk(input ptwPkg::accessT kind, input logic isData, input logic updEn);
    @(posedge clk);
    tlbMiss    <= 1'b1;
    missIsData <= isData;
    access     <= kind;
    adUpdateEn <= updEn;
    vAdr       <= testVa;
    rdLog.delete();
    wrAdrLog.delete();
    wrDataLog.delete();
    latency = 0;
    @(negedge clk);
    while (!(itlbWrite || dtlbWrite || pageFault || accessFault)) begin
      latency++;
      @(negedge clk);
    end
    {gotItlb, gotDtlb, gotPf, gotAf} = {itlbWrite, dtlbWrite, pageFault, accessFault};
    gotPte  = pte;
    gotType = pageType;
    @(posedge clk);
    tlbMiss <= 1'b0;
  endtask

  task automatic checkOutcome(input logic itlb, input logic dtlb, input logic pf, input logic af);
    compareVal("itlbWrite", gotItlb, itlb);
    compareVal("dtlbWrite", gotDtlb, dtlb);
    compareVal("pageFault", gotPf, pf);
    compareVal("accessFault", gotAf, af);
  endtask

  task automatic checkReads(input int leafLvl);
    compareVal("read count", rdLog.size(), 3 - leafLvl);
    for (int i = 0; i < rdLog.size() && i < 3 - leafLvl; i++) begin
      compareVal($sformatf("read address %0d", i), rdLog[i], entryAdr(tblPpn(2 - i), vpnOf(2 - i)));
    end
  endtask

  task automatic reportTest(input string name);
    $display("test %s done, %0d errors", name, errors - testErrs);
    testErrs = errors;
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////
  task automatic kilopageLoad(input bit checkTiming);
    buildWalk(0, mkPte(pagePpn, 10'h0c3));
    runWalk(ptwPkg::LOAD, 1'b1, 1'b0);
    checkOutcome(1'b0, 1'b1, 1'b0, 1'b0);
    compareVal("pte", gotPte, mkPte(pagePpn, 10'h0c3));
    compareVal("pageType", gotType, 2'd0);
    checkReads(0);
    if (checkTiming) compareVal("cycles to LEAF", latency, 7);
  endtask

  task automatic gigapageFetch();
    buildWalk(2, mkPte(44'h4_0000, 10'h049));  // low 18 ppn bits clear
    runWalk(ptwPkg::FETCH, 1'b0, 1'b0);
    checkOutcome(1'b1, 1'b0, 1'b0, 1'b0);
    compareVal("pageType", gotType, 2'd2);
    compareVal("pte", gotPte, mkPte(44'h4_0000, 10'h049));
    buildWalk(2, mkPte(44'h4_0001, 10'h049));  // misaligned superpage
    runWalk(ptwPkg::FETCH, 1'b0, 1'b0);
    checkOutcome(1'b0, 1'b0, 1'b1, 1'b0);
  endtask

  task automatic permissionRules();
    buildWalk(0, mkPte(pagePpn, 10'h0c3));  // read only leaf
    runWalk(ptwPkg::STORE, 1'b1, 1'b0);
    checkOutcome(1'b0, 1'b0, 1'b1, 1'b0);
    buildWalk(0, mkPte(44'h103, 10'h001));  // pointer at level 0
    runWalk(ptwPkg::LOAD, 1'b1, 1'b0);
    checkOutcome(1'b0, 1'b0, 1'b1, 1'b0);
    buildWalk(0, mkPte(pagePpn, 10'h0cd));  // W without R
    runWalk(ptwPkg::LOAD, 1'b1, 1'b0);
    checkOutcome(1'b0, 1'b0, 1'b1, 1'b0);
  endtask

  task automatic adUpdate();
    buildWalk(0, mkPte(pagePpn, 10'h007));  // A and D clear
    runWalk(ptwPkg::STORE, 1'b1, 1'b1);
    checkOutcome(1'b0, 1'b1, 1'b0, 1'b0);
    compareVal("write count", wrAdrLog.size(), 1);
    if (wrAdrLog.size() > 0) begin
      compareVal("write address", wrAdrLog[0], entryAdr(tblPpn(0), vpnOf(0)));
      compareVal("write data", wrDataLog[0], mkPte(pagePpn, 10'h0c7));
    end
    compareVal("pte", gotPte, mkPte(pagePpn, 10'h0c7));
    buildWalk(0, mkPte(pagePpn, 10'h007));
    runWalk(ptwPkg::STORE, 1'b1, 1'b0);  // updates off
    checkOutcome(1'b0, 1'b0, 1'b1, 1'b0);
    compareVal("write count", wrAdrLog.size(), 0);
  endtask

  task automatic accessFaultL1();
    buildWalk(0, mkPte(pagePpn, 10'h0c3));
    faultSet[entryAdr(tblPpn(1), vpnOf(1))] = 1'b1;
    runWalk(ptwPkg::LOAD, 1'b1, 1'b0);
    checkOutcome(1'b0, 1'b0, 1'b0, 1'b1);
    @(negedge clk);
    compareVal("walkBusy", walkBusy, 1'b0);
  endtask

  task automatic stallAndFlush();
    stallOn = 1'b1;
    kilopageLoad(1'b0);
    stallOn = 1'b0;
    buildWalk(0, mkPte(pagePpn, 10'h0c3));
    @(posedge clk);
    tlbMiss <= 1'b1;
    access  <= ptwPkg::LOAD;
    for (int i = 0; i < 20 && !memRead; i++) @(negedge clk);
    if (!memRead) begin
      errors++;
      $display("the walk never read memory before the flush");
    end
    @(posedge clk);
    flush   <= 1'b1;
    tlbMiss <= 1'b0;
    @(posedge clk);
    flush <= 1'b0;
    @(negedge clk);
    compareVal("walkBusy after flush", walkBusy, 1'b0);
    kilopageLoad(1'b1);  // clean walk after the flush
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////////////////////////
  initial begin
    {arstN, tlbMiss, missIsData, adUpdateEn, memStall, memAccessFault, flush} = '0;
    access    = ptwPkg::LOAD;
    vAdr      = '0;
    satpPpn   = tblPpn(2);
    memRdData = '0;
    stallOn   = 1'b0;
    repeat (4) @(posedge clk);
    arstN <= 1'b1;
    kilopageLoad(1'b1);
    reportTest("1 kilopage load");
    gigapageFetch();
    reportTest("2 gigapage fetch");
    permissionRules();
    reportTest("3 permissions");
    adUpdate();
    reportTest("4 A/D update");
    accessFaultL1();
    reportTest("5 access fault");
    stallAndFlush();
    reportTest("6 stall and flush");
    errors += u_ptwTop.u_walkFsm.u_ptwProps.assertFails;  // failed FSM properties
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    #(wdCycles * clkPeriod);
    $display("timeout, the walks did not finish within %0d cycles", wdCycles);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* ptwProps.sv */
// concurrent checks on the walk FSM strobes, pulses and stall behaviour
`timescale 1ns/100ps

module ptwProps (
  input logic              clk,
  input logic              arstN,
  input ptwPkg::walkStateT state,
  input logic              memStall,
  input logic              flush,
  input logic              memRead,
  input logic              memWrite,
  input logic              itlbWrite,
  input logic              dtlbWrite,
  input logic              pageFault,
  input logic              accessFault,
  input logic              walkBusy
);

  int assertFails = 0;  // failed properties so far

  // one memory access at a time
  memOneDir: assert property (@(posedge clk) disable iff (!arstN) !(memRead && memWrite))
    else begin
      $error("memRead and memWrite high together");
      assertFails++;
    end

  fillOrFault: assert property (@(posedge clk) disable iff (!arstN)
    !((itlbWrite || dtlbWrite) && (pageFault || accessFault)))
    else begin
      $error("TLB write and fault pulse high together");
      assertFails++;
    end

  busyInWalk: assert property (@(posedge clk) disable iff (!arstN)
    (state == ptwPkg::ADR || state == ptwPkg::RD) |-> walkBusy)
    else begin
      $error("walkBusy low during ADR or RD");
      assertFails++;
    end

  // a stalled access holds its state unless flushed
  holdOnStall: assert property (@(posedge clk) disable iff (!arstN)
    ((state == ptwPkg::RD || state == ptwPkg::UPDATE) && memStall && !flush) |=> $stable(state))
    else begin
      $error("state moved while memory stalled");
      assertFails++;
    end

endmodule

bind walkFsm ptwProps u_ptwProps (
  .clk, .arstN, .state, .memStall, .flush, .memRead, .memWrite,
  .itlbWrite, .dtlbWrite, .pageFault, .accessFault, .walkBusy
);

/* ptwTop.sv */
// hardware page table walker top, three-level walk on 64-bit entries
`timescale 1ns/100ps

module ptwTop #(
  parameter  int numLevels = 3,
  localparam int levelW    = $clog2(numLevels),
  localparam int vaBits    = ptwPkg::OFFSET_BITS + numLevels * ptwPkg::VPN_BITS
) (
  input  logic              clk,
  input  logic              arstN,
  input  logic              tlbMiss,
  input  logic              missIsData,      // miss from the data TLB
  input  ptwPkg::accessT    access,
  input  logic [vaBits-1:0] vAdr,
  input  ptwPkg::ppnT       satpPpn,
  input  logic              adUpdateEn,
  input  ptwPkg::pteT       memRdData,
  input  logic              memStall,
  input  logic              memAccessFault,
  input  logic              flush,
  output logic              memRead,
  output logic              memWrite,
  output ptwPkg::paT        memAdr,
  output ptwPkg::pteT       memWrData,
  output ptwPkg::pteT       pte,             // entry to the TLBs
  output logic [levelW-1:0] pageType,
  output logic              itlbWrite,
  output logic              dtlbWrite,
  output logic              pageFault,
  output logic              accessFault,
  output logic              walkBusy
);

  logic              start;
  logic              stepDown;
  logic              capture;
  logic              markAd;
  logic [levelW-1:0] level;
  pteStatusIf        status ();

  levelCounter #(.numLevels(numLevels)) u_levelCounter (
    .clk, .arstN, .start, .stepDown, .level, .pageType
  );

  walkAddrGen #(.numLevels(numLevels)) u_walkAddrGen (
    .clk, .arstN, .start, .vAdr, .satpPpn, .level, .pte, .memWrite, .memAdr
  );

  pteCheck #(.numLevels(numLevels)) u_pteCheck (
    .clk, .arstN, .start, .access, .adUpdateEn, .level, .pte, .status(status.check)
  );

  pteStore u_pteStore (
    .clk, .arstN, .capture, .markAd, .memRdData, .access, .pte, .memWrData
  );

  walkFsm u_walkFsm (
    .clk, .arstN, .tlbMiss, .missIsData, .memStall, .memAccessFault, .flush,
    .status(status.fsm),
    .start, .stepDown, .capture, .markAd, .memRead, .memWrite,
    .itlbWrite, .dtlbWrite, .pageFault, .accessFault, .walkBusy
  );

endmodule

/* walkFsm.sv */
// page table walk FSM, drives memory strobes, TLB writes and fault pulses
`timescale 1ns/100ps

module walkFsm (
  input  logic      clk,
  input  logic      arstN,
  input  logic      tlbMiss,         // held until the walk ends
  input  logic      missIsData,
  input  logic      memStall,
  input  logic      memAccessFault,
  input  logic      flush,
  pteStatusIf.fsm   status,
  output logic      start,
  output logic      stepDown,
  output logic      capture,
  output logic      markAd,
  output logic      memRead,
  output logic      memWrite,
  output logic      itlbWrite,
  output logic      dtlbWrite,
  output logic      pageFault,
  output logic      accessFault,
  output logic      walkBusy
);

  ptwPkg::walkStateT state;
  ptwPkg::walkStateT nextState;
  logic              dataWalk;   // walk fills the data TLB
  logic              topLvl;     // still at the root level
  logic              accFaultQ;  // FAULT came from a failed read
  logic              rdDone;
  logic              tlbWrite;

  //////////////////////////////////////////////////////////////////////
  // strobes
  //////////////////////////////////////////////////////////////////////
  assign start    = (state == ptwPkg::IDLE) & tlbMiss;
  assign rdDone   = (state == ptwPkg::RD) & ~memStall;
  assign capture  = rdDone & ~memAccessFault;
  assign stepDown = (state == ptwPkg::ADR) & ~topLvl & status.descend;
  assign markAd   = (state == ptwPkg::LEAF) & status.needUpdate;
  assign memRead  = (state == ptwPkg::RD);
  assign memWrite = (state == ptwPkg::UPDATE);

  assign tlbWrite    = (state == ptwPkg::LEAF) & status.leafOk;
  assign itlbWrite   = tlbWrite & ~dataWalk;
  assign dtlbWrite   = tlbWrite & dataWalk;
  assign pageFault   = (state == ptwPkg::FAULT) & ~accFaultQ;
  assign accessFault = (state == ptwPkg::FAULT) & accFaultQ;

  assign walkBusy = ((state != ptwPkg::IDLE) & (state != ptwPkg::FAULT)) |
                    ((state == ptwPkg::IDLE) & tlbMiss);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      dataWalk  <= 1'b0;
      topLvl    <= 1'b0;
      accFaultQ <= 1'b0;
    end else begin
      if (start) dataWalk <= missIsData;
      if (start)        topLvl <= 1'b1;
      else if (capture) topLvl <= 1'b0;  // root entry is in
      accFaultQ <= rdDone & memAccessFault;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////
  // in RD the entry register still holds the parent pointer and level is the
  // level being read, so descend low there means this read is at level 0
  always_comb begin
    case (state)
      ptwPkg::IDLE:   nextState = tlbMiss ? ptwPkg::ADR : ptwPkg::IDLE;
      ptwPkg::ADR:    nextState = (topLvl || status.descend) ? ptwPkg::RD : ptwPkg::LEAF;
      ptwPkg::RD: begin
        if (memStall)                      nextState = ptwPkg::RD;
        else if (memAccessFault)           nextState = ptwPkg::FAULT;
        else if (!topLvl && !status.descend) nextState = ptwPkg::LEAF;  // level 0 entry
        else                               nextState = ptwPkg::ADR;
      end
      ptwPkg::LEAF: begin
        if (status.leafOk)          nextState = ptwPkg::IDLE;
        else if (status.needUpdate) nextState = ptwPkg::UPDATE;
        else                        nextState = ptwPkg::FAULT;
      end
      ptwPkg::UPDATE: nextState = memStall ? ptwPkg::UPDATE : ptwPkg::LEAF;  // back to fill TLB
      default:        nextState = ptwPkg::IDLE;  // FAULT lasts one cycle
    endcase
    if (flush) nextState = ptwPkg::IDLE;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) state <= ptwPkg::IDLE;
    else        state <= nextState;
  end

endmodule

/* pteStore.sv */
// page table entry register, with the A/D marked copy for the write back
`timescale 1ns/100ps

module pteStore (
  input  logic           clk,
  input  logic           arstN,
  input  logic           capture,    // read done
  input  logic           markAd,     // entering UPDATE
  input  ptwPkg::pteT    memRdData,
  input  ptwPkg::accessT access,
  output ptwPkg::pteT    pte,
  output ptwPkg::pteT    memWrData   // entry with A, and D on a store
);

  // the same value is written to memory and kept for the TLB
  always_comb begin
    memWrData                 = pte;
    memWrData[ptwPkg::PTE_A]  = 1'b1;
    if (access == ptwPkg::STORE) begin
      memWrData[ptwPkg::PTE_D] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pte <= '0;
    end else if (capture) begin
      pte <= memRdData;
    end else if (markAd) begin
      pte <= memWrData;
    end
  end

endmodule

/* pteCheck.sv */
// page table entry checker, decides descend, leaf ok, A/D update or page fault
`timescale 1ns/100ps

module pteCheck #(
  parameter  int numLevels = 3,
  localparam int levelW    = $clog2(numLevels)
) (
  input  logic              clk,
  input  logic              arstN,
  input  logic              start,
  input  ptwPkg::accessT    access,
  input  logic              adUpdateEn,  // hardware A/D update allowed
  input  logic [levelW-1:0] level,
  input  ptwPkg::pteT       pte,
  pteStatusIf.check         status
);

  ptwPkg::accessT accessQ;    // kind of access that missed
  ptwPkg::ppnT    ppn;
  ptwPkg::ppnT    alignMask;  // low ppn bits a superpage must clear
  logic           badEnc;
  logic           pointer;
  logic           misaligned;
  logic           noPerm;
  logic           adMissing;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN)     accessQ <= ptwPkg::FETCH;
    else if (start) accessQ <= access;
  end

  // W without R is reserved
  assign badEnc  = ~pte[ptwPkg::PTE_V] | (pte[ptwPkg::PTE_W] & ~pte[ptwPkg::PTE_R]);
  assign pointer = ~(pte[ptwPkg::PTE_R] | pte[ptwPkg::PTE_W] | pte[ptwPkg::PTE_X]);

  assign ppn        = pte[ptwPkg::PPN_LSB +: ptwPkg::PPN_BITS];
  assign alignMask  = (ptwPkg::ppnT'(1) << (level * ptwPkg::VPN_BITS)) - ptwPkg::ppnT'(1);
  assign misaligned = |(ppn & alignMask);

  always_comb begin
    case (accessQ)
      ptwPkg::FETCH: noPerm = ~pte[ptwPkg::PTE_X];
      ptwPkg::STORE: noPerm = ~pte[ptwPkg::PTE_W];
      default:       noPerm = ~pte[ptwPkg::PTE_R];  // load
    endcase
  end

  assign adMissing = ~pte[ptwPkg::PTE_A] | ((accessQ == ptwPkg::STORE) & ~pte[ptwPkg::PTE_D]);

  // exactly one verdict
  always_comb begin
    status.descend    = 1'b0;
    status.leafOk     = 1'b0;
    status.needUpdate = 1'b0;
    status.fault      = 1'b0;
    if (badEnc) begin
      status.fault = 1'b1;
    end else if (pointer) begin
      if (level != '0) status.descend = 1'b1;
      else             status.fault   = 1'b1;  // no table below level 0
    end else if (misaligned || noPerm) begin
      status.fault = 1'b1;
    end else if (adMissing) begin
      if (adUpdateEn) status.needUpdate = 1'b1;
      else            status.fault      = 1'b1;  // software owns A/D
    end else begin
      status.leafOk = 1'b1;
    end
  end

endmodule

/* walkAddrGen.sv */
// entry address generator, holds the virtual address and the leaf entry address
`timescale 1ns/100ps

module walkAddrGen #(
  parameter  int numLevels = 3,
  localparam int levelW    = $clog2(numLevels),
  localparam int vaBits    = ptwPkg::OFFSET_BITS + numLevels * ptwPkg::VPN_BITS
) (
  input  logic              clk,
  input  logic              arstN,
  input  logic              start,
  input  logic [vaBits-1:0] vAdr,
  input  ptwPkg::ppnT       satpPpn,   // root table page
  input  logic [levelW-1:0] level,
  input  ptwPkg::pteT       pte,       // entry register
  input  logic              memWrite,  // A/D write back in progress
  output ptwPkg::paT        memAdr
);

  logic [vaBits-1:0]          vAdrQ;
  logic [levelW-1:0]          levelQ;   // level seen last cycle
  logic [ptwPkg::VPN_BITS-1:0] vpn;
  ptwPkg::ppnT                basePpn;
  ptwPkg::paT                 rdAdr;
  ptwPkg::paT                 leafAdr;  // address of the last entry read
  logic                       newLevel;

  // vpn field of the current level
  assign vpn = vAdrQ[ptwPkg::OFFSET_BITS + level * ptwPkg::VPN_BITS +: ptwPkg::VPN_BITS];

  // root table from satp, lower tables from the pointer held in the entry register
  assign basePpn = (level == levelW'(numLevels - 1)) ?
                   satpPpn : pte[ptwPkg::PPN_LSB +: ptwPkg::PPN_BITS];
  assign rdAdr   = {basePpn, vpn, {ptwPkg::ENTRY_SHIFT{1'b0}}};

  // first cycle at a level, the pointer is still the parent entry
  assign newLevel = (level != levelQ);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) levelQ <= '0;
    else        levelQ <= level;
  end

  always_ff @(posedge clk) begin
    if (start) begin
      vAdrQ   <= vAdr;
      leafAdr <= {satpPpn,
                  vAdr[ptwPkg::OFFSET_BITS + (numLevels - 1) * ptwPkg::VPN_BITS +: ptwPkg::VPN_BITS],
                  {ptwPkg::ENTRY_SHIFT{1'b0}}};  // root entry
    end else if (newLevel) begin
      leafAdr <= rdAdr;
    end
  end

  assign memAdr = memWrite ? leafAdr : rdAdr;  // write back goes to the leaf slot

endmodule

/* levelCounter.sv */
// walk level counter, loads the top level at start and steps down per level
`timescale 1ns/100ps

module levelCounter #(
  parameter  int numLevels = 3,
  localparam int levelW    = $clog2(numLevels)
) (
  input  logic              clk,
  input  logic              arstN,
  input  logic              start,     // walk begins
  input  logic              stepDown,  // entering next level's read
  output logic [levelW-1:0] level,
  output logic [levelW-1:0] pageType   // 0 kilopage, 1 megapage, 2 gigapage
);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      level <= '0;
    end else if (start) begin
      level <= levelW'(numLevels - 1);  // root table
    end else if (stepDown && (level != '0)) begin
      level <= level - levelW'(1);
    end
  end

  // the walk stops at the leaf, so the level held then is the page size
  assign pageType = level;

endmodule

/* pteStatusIf.sv */
// verdict on the held page table entry, from the entry checker to the walk FSM
`timescale 1ns/100ps

interface pteStatusIf;

  // one-hot while the walker judges an entry
  logic descend;     // valid pointer, level above 0
  logic leafOk;      // leaf that can go to the TLB as is
  logic needUpdate;  // leaf missing A, or D on a store, updates on
  logic fault;       // everything else

  modport check (
    output descend,
    output leafOk,
    output needUpdate,
    output fault
  );

  modport fsm (
    input descend,
    input leafOk,
    input needUpdate,
    input fault
  );

endinterface

/* ptwPkg.sv */
// page table walker package with entry layout, widths and shared types
package ptwPkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////
  localparam int PTE_BITS    = 64;  // one page table entry
  localparam int PPN_BITS    = 44;  // physical page number
  localparam int PA_BITS     = 56;  // physical address
  localparam int VPN_BITS    = 9;   // one vpn field per level
  localparam int OFFSET_BITS = 12;  // 4 KiB page offset
  localparam int ENTRY_SHIFT = 3;   // 8 byte entries

  // entry bit positions
  localparam int PTE_V   = 0;
  localparam int PTE_R   = 1;
  localparam int PTE_W   = 2;
  localparam int PTE_X   = 3;
  localparam int PTE_A   = 6;  // accessed
  localparam int PTE_D   = 7;  // dirty
  localparam int PPN_LSB = 10;

  //////////////////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////////////////
  typedef logic [PTE_BITS-1:0] pteT;
  typedef logic [PPN_BITS-1:0] ppnT;
  typedef logic [PA_BITS-1:0]  paT;

  typedef enum logic [1:0] {
    FETCH = 2'd0,
    LOAD  = 2'd1,
    STORE = 2'd2
  } accessT;

  // ADR judges the entry of the level above, RD waits on memory
  typedef enum logic [2:0] {IDLE, ADR, RD, LEAF, UPDATE, FAULT} walkStateT;

endpackage
